//--- filelist.f
+incdir+.
st_cfg_pkg.sv
st_io_pkg.sv
db9_router.sv
audio_volume.sv
boot_control.sv
st_glue_top.sv
st_glue_sva.sv
st_glue_tb.sv

//--- Makefile
VERILATOR   ?= verilator
TOP         ?= st_glue_tb
FILELIST    ?= filelist.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 1000
JOBS        ?= 0
VFLAGS      ?= --binary --timing --assert -j $(JOBS)
PASS_TEXT   ?= TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator status is ignored, the log decides
run: build
	-./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- st_glue_tb.sv
// st glue testbench: stimulus for routing, port 0 arbitration, volume, boot and ram scramble
`default_nettype none

module st_glue_tb;

  localparam int unsigned PERIOD  = 100;
  localparam int unsigned SD_WAIT = 200; // short image wait for simulation
  localparam int unsigned ROUTE_N = 16;  // random vectors per mouse/joystick combination
  localparam int unsigned VOL_N   = 32;  // random samples per volume step
  // resets, routing, volume and two image waits, plus margin for the short tests
  localparam int unsigned RUN_CYCLES =
    6 * 4 + 9 * (ROUTE_N + 1) + 4 * (VOL_N + 1) + 2 * SD_WAIT + 200;

  logic                  clk32;
  logic                  rst_n;
  st_cfg_pkg::sys_cfg_t  cfg;
  st_io_pkg::db9_pins_t  io;
  st_io_pkg::db9_pins_t  spare;
  st_io_pkg::st_port_t   hid_mouse;
  st_io_pkg::hid_joys_t  hid_joy;
  st_io_pkg::sample_in_t audio_l;
  st_io_pkg::sample_in_t audio_r;
  logic                  ram_ready;
  logic                  flash_ready;
  logic                  user_reset;
  logic                  img_size_nz;
  st_io_pkg::ram_addr_t  ram_a;
  st_io_pkg::st_port_t   joy0;
  st_io_pkg::st_port_t   joy1;
  st_io_pkg::st_port_t   hid_db9;
  st_io_pkg::par_in_t    par_in;
  st_io_pkg::sample_t    audio_out_l;
  st_io_pkg::sample_t    audio_out_r;
  logic                  core_resb;
  logic                  sd_ready;
  st_io_pkg::ram_addr_t  ram_a_s;

  logic [31:0] seed = 32'hb1bf; // xorshift state
  int          tests_run;

  st_glue_top #(.SD_WAIT_CYCLES(SD_WAIT)) UUT (.*);

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] next_random();
    seed = xorshift(seed);
    return seed;
  endfunction

  // new random pins, hid state, samples and ram address
  task automatic randomize_io();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    a = next_random();
    b = next_random();
    c = next_random();
    io        = a[5:0];
    spare     = a[11:6];
    hid_mouse = a[17:12];
    audio_l   = b[14:0];
    audio_r   = b[29:15];
    hid_joy   = c[23:0];
    ram_a     = {c[31:24], a[31:18]};
  endtask

  task automatic run_random(int unsigned n);
    repeat (n) begin
      @(negedge clk32);
      randomize_io();
    end
  endtask

  task automatic step(int unsigned n);
    repeat (n) @(negedge clk32);
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (4) @(negedge clk32);
    rst_n = 1'b1;
  endtask

  // boot tests end when sd_ready comes up
  task automatic wait_sd_ready();
    while (!sd_ready) @(negedge clk32);
  endtask

  task automatic finish_test(string name);
    tests_run++;
    $display("%s finished at %0t, assertion failures so far %0d", name, $time,
             UUT.u_sva.err_cnt);
  endtask

  initial begin
    clk32 = 1'b0;
    forever #(PERIOD / 2) clk32 = ~clk32;
  end

  initial begin
    #(RUN_CYCLES * PERIOD);
    $display("watchdog expired at %0t, the tests did not finish", $time);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    tests_run   = 0;
    cfg         = '0; // hid mouse, no db9 sticks, muted
    io          = '1; // db9 pins idle high
    spare       = '1;
    hid_mouse   = '0;
    hid_joy     = '0;
    audio_l     = '0;
    audio_r     = '0;
    ram_ready   = 1'b0;
    flash_ready = 1'b0;
    user_reset  = 1'b0;
    img_size_nz = 1'b0;
    ram_a       = '0;
    apply_reset();

    // every mouse source against every db9 stick count
    for (int ms = 0; ms < 3; ms++) begin
      for (int jc = 0; jc < 3; jc++) begin
        @(negedge clk32);
        cfg.mouse_src = st_cfg_pkg::mouse_src_e'(ms[1:0]);
        cfg.joy_cfg   = st_cfg_pkg::joy_cfg_e'(jc[1:0]);
        run_random(ROUTE_N);
      end
    end
    finish_test("port routing");

    // port 0: mouse after reset, stick fire takes over, mouse button hands back
    cfg.mouse_src = st_cfg_pkg::msrc_hid;
    cfg.joy_cfg   = st_cfg_pkg::joy_none; // port 0 stick is hid joystick 1
    hid_mouse     = '0;
    hid_joy       = '0;
    apply_reset();
    hid_mouse.up = 1'b1;
    step(2);
    hid_joy[1].fire = 1'b1;
    step(1);
    hid_joy[1].fire = 1'b0;
    hid_joy[1].left = 1'b1;
    step(3);
    hid_mouse.fire = 1'b1;
    step(1);
    hid_mouse.fire = 1'b0;
    step(2);
    finish_test("port 0 arbitration");

    for (int v = 0; v < 4; v++) begin
      @(negedge clk32);
      cfg.volume = st_cfg_pkg::volume_e'(v[1:0]);
      run_random(VOL_N);
    end
    finish_test("volume");

    // image shows up early, then each reset source is pulled once
    apply_reset();
    step(5);
    img_size_nz = 1'b1;
    wait_sd_ready();
    img_size_nz = 1'b0;
    ram_ready   = 1'b1;
    flash_ready = 1'b1;
    step(2);
    cfg.reset_req = 1'b1;
    step(2);
    cfg.reset_req = 1'b0;
    user_reset    = 1'b1;
    step(2);
    user_reset = 1'b0;
    step(2);
    finish_test("boot by image");

    apply_reset(); // no image this time
    wait_sd_ready();
    step(2);
    finish_test("boot by timeout");

    for (int k = 0; k < 6; k++) begin
      @(negedge clk32);
      cfg.coldboot = 1'b1; // held three cycles, counts once
      randomize_io();
      run_random(2);
      @(negedge clk32);
      cfg.coldboot = 1'b0;
      run_random(2);
    end
    step(1);
    finish_test("ram scramble");

    $display("%0d tests run, %0d assertion failures", tests_run, UUT.u_sva.err_cnt);
    if (UUT.u_sva.err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- st_glue_sva.sv
// st glue checker: concurrent assertions on routing, port 0 owner, volume, boot and ram scramble
`default_nettype none

`include "st_glue_consts.svh"

module st_glue_sva #(
  parameter int unsigned WAIT_CYCLES = `ST_SD_WAIT_DEFAULT
) (
  input wire logic                  clk32, rst_n, ram_ready, flash_ready,
  input wire logic                  user_reset, img_size_nz, core_resb, sd_ready,
  input wire st_cfg_pkg::sys_cfg_t  cfg,
  input wire st_io_pkg::db9_pins_t  io, spare,
  input wire st_io_pkg::st_port_t   hid_mouse, joy0, joy1, hid_db9,
  input wire st_io_pkg::hid_joys_t  hid_joy,
  input wire st_io_pkg::par_in_t    par_in,
  input wire st_io_pkg::sample_in_t audio_l, audio_r,
  input wire st_io_pkg::sample_t    audio_out_l, audio_out_r,
  input wire st_io_pkg::ram_addr_t  ram_a, ram_a_s
);

  // db9 connector seen as an active high port, amiga mice swap up and right
  function automatic st_io_pkg::st_port_t db9_view(st_io_pkg::db9_pins_t p, logic amiga);
    st_io_pkg::st_port_t v;
    v.up    = amiga ? !p[2] : !p[3];
    v.down  = !p[4];
    v.left  = !p[1];
    v.right = amiga ? !p[3] : !p[2];
    v.fire  = !p[0];
    v.fire2 = !p[5];
    return v;
  endfunction

  // stick on ports 0..3, entry 0 is the joystick side of port 0
  function automatic st_io_pkg::hid_joys_t port_table(st_cfg_pkg::sys_cfg_t c,
      st_io_pkg::db9_pins_t i, st_io_pkg::db9_pins_t s, st_io_pkg::hid_joys_t h);
    logic                mdb9;
    st_io_pkg::st_port_t stick;
    mdb9  = (c.mouse_src != st_cfg_pkg::msrc_hid); // mouse takes the io db9
    stick = mdb9 ? db9_view(s, 1'b0) : db9_view(i, 1'b0);
    case (c.joy_cfg)
      st_cfg_pkg::joy_none: port_table = {h[3], h[2], h[0], h[1]};
      st_cfg_pkg::joy_one:  port_table = {h[2], h[1], stick, h[0]};
      default: port_table = mdb9 ? {h[2], h[1], stick, h[0]}
                                 : {h[1], h[0], db9_view(i, 1'b0), db9_view(s, 1'b0)};
    endcase
  endfunction

  // sign extension by size cast, then the volume shift
  function automatic st_io_pkg::sample_t vol_scale(st_io_pkg::sample_in_t s,
                                                   st_cfg_pkg::volume_e v);
    st_io_pkg::sample_t wide;
    wide = st_io_pkg::sample_t'(s);
    case (v)
      st_cfg_pkg::vol_mute:    return '0;
      st_cfg_pkg::vol_quarter: return wide >>> 2;
      st_cfg_pkg::vol_half:    return wide >>> 1;
      default:                 return wide;
    endcase
  endfunction

  st_io_pkg::hid_joys_t ports;      // expected sticks per port
  st_io_pkg::st_port_t  mouse;      // expected port 0 mouse
  st_io_pkg::par_in_t   exp_par;
  st_io_pkg::sample_t   exp_l, exp_r;
  logic                 started;    // set by the first reset
  logic                 mouse_sel;  // port 0 owner model, high for mouse
  logic                 cb_last;
  logic [1:0]           cb_count;   // coldboot rising edges, wraps at 4
  int unsigned          run_cycles; // edges since reset ended
  int                   err_cnt;

  initial err_cnt = 0;

  assign ports = port_table(cfg, io, spare, hid_joy);
  assign mouse = (cfg.mouse_src == st_cfg_pkg::msrc_hid) ? hid_mouse :
                 db9_view(io, cfg.mouse_src == st_cfg_pkg::msrc_amiga_db9);

  // gauntlet ii adapter: port 2 directions in the high nibble, up first
  always_comb begin
    exp_par.strobe = !ports[3].fire;
    exp_par.busy   = !ports[2].fire;
    for (int k = 0; k < 4; k++) begin
      exp_par.data[7-k] = !ports[2][k];
      exp_par.data[3-k] = !ports[3][k];
    end
  end

  always_ff @(posedge clk32) begin
    if (!rst_n) started <= 1'b1;
    if (!rst_n) begin
      mouse_sel  <= 1'b1;
      cb_last    <= 1'b0;
      cb_count   <= 2'd0;
      run_cycles <= 0;
      exp_l      <= '0;
      exp_r      <= '0;
    end else begin
      if (mouse.fire || mouse.fire2) mouse_sel <= 1'b1; // mouse button wins
      else if (ports[0].fire || ports[0].fire2) mouse_sel <= 1'b0;
      cb_last <= cfg.coldboot;
      if (cfg.coldboot && !cb_last) cb_count <= cb_count + 2'd1;
      run_cycles <= run_cycles + 1;
      exp_l <= vol_scale(audio_l, cfg.volume); // one cycle latency
      exp_r <= vol_scale(audio_r, cfg.volume);
    end
  end

  a_joy1: assert property (@(posedge clk32) started |-> joy1 == ports[1])
    else begin err_cnt++; $error("Mismatch at %0t: joy1 %h, expected %h", $time, joy1, ports[1]); end
  a_par: assert property (@(posedge clk32) started |-> par_in == exp_par)
    else begin err_cnt++; $error("Mismatch at %0t: par_in %h, expected %h", $time, par_in, exp_par); end
  a_hid_db9: assert property (@(posedge clk32) started |->
      hid_db9 == ((cfg.mouse_src == st_cfg_pkg::msrc_hid) ? db9_view(io, 1'b0) : db9_view(spare, 1'b0)))
    else begin err_cnt++; $error("Mismatch at %0t: hid_db9 %h", $time, hid_db9); end
  a_joy0: assert property (@(posedge clk32) started |-> joy0 == (mouse_sel ? mouse : ports[0]))
    else begin err_cnt++; $error("Mismatch at %0t: joy0 %h, mouse owner %b", $time, joy0, mouse_sel); end
  a_audio: assert property (@(posedge clk32) started |-> audio_out_l == exp_l && audio_out_r == exp_r)
    else begin err_cnt++; $error("Mismatch at %0t: audio %h/%h, expected %h/%h", $time,
                                 audio_out_l, audio_out_r, exp_l, exp_r); end
  a_sd_reset: assert property (@(posedge clk32) started && !rst_n |=> !sd_ready)
    else begin err_cnt++; $error("sd_ready was still high at %0t after a reset", $time); end
  a_sd_image: assert property (@(posedge clk32) started && rst_n && img_size_nz |=> sd_ready)
    else begin err_cnt++; $error("sd_ready did not rise at %0t after the image showed up", $time); end
  a_sd_timeout: assert property (@(posedge clk32)
      started && rst_n && run_cycles == WAIT_CYCLES - 1 |=> sd_ready)
    else begin err_cnt++; $error("sd_ready did not rise at %0t when the wait ran out", $time); end
  a_sd_early: assert property (@(posedge clk32) started && rst_n && !sd_ready && !img_size_nz
      && run_cycles < WAIT_CYCLES - 1 |=> !sd_ready)
    else begin err_cnt++; $error("sd_ready rose too early at %0t without an image", $time); end
  a_sd_hold: assert property (@(posedge clk32) started && rst_n && sd_ready |=> sd_ready)
    else begin err_cnt++; $error("sd_ready dropped at %0t without a reset", $time); end
  a_core_resb: assert property (@(posedge clk32) started |-> core_resb == (sd_ready && ram_ready
      && flash_ready && !cfg.reset_req && !user_reset && rst_n))
    else begin err_cnt++; $error("Mismatch at %0t: core_resb %b", $time, core_resb); end
  a_scramble: assert property (@(posedge clk32) started |->
      ram_a_s == (ram_a ^ (st_io_pkg::ram_addr_t'(cb_count) << `ST_SCRAMBLE_LSB)))
    else begin err_cnt++; $error("Mismatch at %0t: ram_a_s %h for ram_a %h, count %0d", $time,
                                 ram_a_s, ram_a, cb_count); end

endmodule

// checker rides along inside every st glue top
bind st_glue_top st_glue_sva #(.WAIT_CYCLES(SD_WAIT_CYCLES)) u_sva (.*);

`default_nettype wire

//--- st_glue_top.sv
// st glue top: joystick routing, audio volume and boot/reset control of the st core
`default_nettype none

`include "st_glue_consts.svh"

module st_glue_top #(
  parameter int unsigned SD_WAIT_CYCLES = `ST_SD_WAIT_DEFAULT
) (
  input  wire logic                 clk32,
  input  wire logic                 rst_n,
  input  wire st_cfg_pkg::sys_cfg_t cfg,         // osd settings
  input  wire st_io_pkg::db9_pins_t io,
  input  wire st_io_pkg::db9_pins_t spare,
  input  wire st_io_pkg::st_port_t  hid_mouse,
  input  wire st_io_pkg::hid_joys_t hid_joy,
  input  wire st_io_pkg::sample_in_t audio_l,
  input  wire st_io_pkg::sample_in_t audio_r,
  input  wire logic                 ram_ready,
  input  wire logic                 flash_ready,
  input  wire logic                 user_reset,
  input  wire logic                 img_size_nz,
  input  wire st_io_pkg::ram_addr_t ram_a,       // word address from the core
  output st_io_pkg::st_port_t       joy0,
  output st_io_pkg::st_port_t       joy1,
  output st_io_pkg::st_port_t       hid_db9,
  output st_io_pkg::par_in_t        par_in,
  output st_io_pkg::sample_t        audio_out_l,
  output st_io_pkg::sample_t        audio_out_r,
  output logic                      core_resb,
  output logic                      sd_ready,
  output st_io_pkg::ram_addr_t      ram_a_s      // scrambled, towards sdram
);

  db9_router u_router (
    .clk32     (clk32),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .io        (io),
    .spare     (spare),
    .hid_mouse (hid_mouse),
    .hid_joy   (hid_joy),
    .joy0      (joy0),
    .joy1      (joy1),
    .hid_db9   (hid_db9),
    .par_in    (par_in)
  );

  // only the volume field matters for audio
  audio_volume u_audio (
    .clk32       (clk32),
    .rst_n       (rst_n),
    .volume      (cfg.volume),
    .audio_l     (audio_l),
    .audio_r     (audio_r),
    .audio_out_l (audio_out_l),
    .audio_out_r (audio_out_r)
  );

  boot_control #(
    .WAIT_CYCLES (SD_WAIT_CYCLES)
  ) u_boot (
    .clk32       (clk32),
    .rst_n       (rst_n),
    .cfg         (cfg),
    .img_size_nz (img_size_nz),
    .ram_ready   (ram_ready),
    .flash_ready (flash_ready),
    .user_reset  (user_reset),
    .ram_a       (ram_a),
    .sd_ready    (sd_ready),
    .core_resb   (core_resb),
    .ram_a_s     (ram_a_s)
  );

endmodule

`default_nettype wire

//--- boot_control.sv
// boot control waits for an image or timeout, drives the core reset and scrambles ram on cold boot
`default_nettype none

`include "st_glue_consts.svh"

module boot_control #(
  parameter int unsigned WAIT_CYCLES = `ST_SD_WAIT_DEFAULT // image wait in clk32 cycles
) (
  input  wire logic                 clk32,
  input  wire logic                 rst_n,
  input  wire st_cfg_pkg::sys_cfg_t cfg,
  input  wire logic                 img_size_nz, // mounted image has nonzero size
  input  wire logic                 ram_ready,   // sdram init done
  input  wire logic                 flash_ready, // tos rom readable
  input  wire logic                 user_reset,  // board button
  input  wire st_io_pkg::ram_addr_t ram_a,
  output logic                      sd_ready,
  output logic                      core_resb,   // active low reset into the st core
  output st_io_pkg::ram_addr_t      ram_a_s
);

  logic [31:0]                    sd_wait;   // cycles since end of reset
  logic [`ST_SCRAMBLE_W-1:0]      scramble;  // cold boot count that wraps
  logic                           cb_q;      // coldboot of the previous cycle

  // give the mcu time to mount the default image before the st boots
  always_ff @(posedge clk32) begin
    if (!rst_n) begin
      sd_wait  <= '0;
      sd_ready <= 1'b0;
    end else if (!sd_ready) begin
      if (img_size_nz) begin
        sd_ready <= 1'b1; // image is mounted
      end else if ((sd_wait + 32'd1) >= WAIT_CYCLES) begin
        sd_ready <= 1'b1; // no image so boot anyway
      end else begin
        sd_wait <= sd_wait + 32'd1;
      end
    end
  end

  // st core runs only when every source agrees
  assign core_resb = sd_ready && ram_ready && flash_ready &&
                     !cfg.reset_req && !user_reset && rst_n;

  // count rising edges of coldboot
  always_ff @(posedge clk32) begin
    if (!rst_n) begin
      cb_q     <= 1'b0;
      scramble <= '0;
    end else begin
      cb_q <= cfg.coldboot;
      if (cfg.coldboot && !cb_q) begin
        scramble <= scramble + `ST_SCRAMBLE_W'(1);
      end
    end
  end

  // a different scramble value makes the old ram contents look like garbage
  always_comb begin
    ram_a_s = ram_a;
    ram_a_s[`ST_SCRAMBLE_LSB +: `ST_SCRAMBLE_W] =
      ram_a[`ST_SCRAMBLE_LSB +: `ST_SCRAMBLE_W] ^ scramble;
  end

endmodule

`default_nettype wire

//--- audio_volume.sv
// audio volume: sign-extends both core channels to 16 bit and scales them by the volume setting
`default_nettype none

`include "st_glue_consts.svh"

module audio_volume (
  input  wire logic                  clk32,
  input  wire logic                  rst_n,
  input  wire st_cfg_pkg::volume_e   volume,
  input  wire st_io_pkg::sample_in_t audio_l,
  input  wire st_io_pkg::sample_in_t audio_r,
  output st_io_pkg::sample_t         audio_out_l,
  output st_io_pkg::sample_t         audio_out_r
);

  // signed division by powers of two keeps the sign
  function automatic st_io_pkg::sample_t scale(st_io_pkg::sample_in_t s,
                                               st_cfg_pkg::volume_e v);
    st_io_pkg::sample_t ext;
    ext = {s[`ST_AUDIO_IN_W-1], s}; // one bit of sign extension
    case (v)
      st_cfg_pkg::vol_mute:    scale = '0;
      st_cfg_pkg::vol_quarter: scale = ext >>> 2;
      st_cfg_pkg::vol_half:    scale = ext >>> 1;
      default:                 scale = ext; // full
    endcase
  endfunction

  always_ff @(posedge clk32) begin
    if (!rst_n) begin
      audio_out_l <= '0;
      audio_out_r <= '0;
    end else begin
      audio_out_l <= scale(audio_l, volume);
      audio_out_r <= scale(audio_r, volume);
    end
  end

endmodule

`default_nettype wire

//--- db9_router.sv
// joystick and mouse router: maps hid and db9 sources onto st ports 0..3 and the printer port
`default_nettype none

module db9_router (
  input  wire logic                 clk32,
  input  wire logic                 rst_n,
  input  wire st_cfg_pkg::sys_cfg_t cfg,
  input  wire st_io_pkg::db9_pins_t io,        // first db9, mouse or joystick
  input  wire st_io_pkg::db9_pins_t spare,     // second db9, joystick only
  input  wire st_io_pkg::st_port_t  hid_mouse,
  input  wire st_io_pkg::hid_joys_t hid_joy,
  output st_io_pkg::st_port_t       joy0,
  output st_io_pkg::st_port_t       joy1,
  output st_io_pkg::st_port_t       hid_db9,   // db9 state reported back to the mcu
  output st_io_pkg::par_in_t        par_in
);

  // atari wiring of the db9 pins, inverted to active high
  function automatic st_io_pkg::st_port_t atari_view(st_io_pkg::db9_pins_t p);
    atari_view = ~{p[5], p[0], p[2], p[1], p[4], p[3]};
  endfunction

  // amiga mice swap two quadrature lines against the atari ones
  function automatic st_io_pkg::st_port_t amiga_view(st_io_pkg::db9_pins_t p);
    amiga_view = ~{p[5], p[0], p[3], p[1], p[4], p[2]};
  endfunction

  st_io_pkg::st_port_t db9_0_atari; // io as atari device
  st_io_pkg::st_port_t db9_0_amiga; // io as amiga mouse
  st_io_pkg::st_port_t db9_1;       // spare, always atari
  st_io_pkg::st_port_t port0_mouse;
  st_io_pkg::st_port_t port0_joy;
  st_io_pkg::st_port_t port2;       // gauntlet adapter joystick 3
  st_io_pkg::st_port_t port3;       // gauntlet adapter joystick 4
  logic                mouse_db9;   // a db9 port is taken by the mouse
  logic                mouse_active;

  assign db9_0_atari = atari_view(io);
  assign db9_0_amiga = amiga_view(io);
  assign db9_1       = atari_view(spare);
  assign mouse_db9   = (cfg.mouse_src != st_cfg_pkg::msrc_hid);

  always_comb begin
    // port 0 mouse
    case (cfg.mouse_src)
      st_cfg_pkg::msrc_hid:       port0_mouse = hid_mouse;
      st_cfg_pkg::msrc_atari_db9: port0_mouse = db9_0_atari;
      default:                    port0_mouse = db9_0_amiga;
    endcase

    // every db9 joystick in use pushes the hid ones one port further out
    case (cfg.joy_cfg)
      st_cfg_pkg::joy_none: begin
        port0_joy = hid_joy[1]; // second hid stick overlays the mouse
        joy1      = hid_joy[0]; // first hid stick on the default port
        port2     = hid_joy[2];
        port3     = hid_joy[3];
      end
      st_cfg_pkg::joy_one: begin
        port0_joy = hid_joy[0];
        joy1      = mouse_db9 ? db9_1 : db9_0_atari;
        port2     = hid_joy[1];
        port3     = hid_joy[2];
      end
      st_cfg_pkg::joy_two: begin
        // with a db9 mouse only one db9 port is left for a stick
        port0_joy = mouse_db9 ? hid_joy[0] : db9_1;
        joy1      = mouse_db9 ? db9_1 : db9_0_atari;
        port2     = mouse_db9 ? hid_joy[1] : hid_joy[0];
        port3     = mouse_db9 ? hid_joy[2] : hid_joy[1];
      end
      default: begin
        port0_joy = db9_1;
        joy1      = mouse_db9 ? db9_1 : db9_0_atari;
        port2     = mouse_db9 ? hid_joy[1] : hid_joy[0];
        port3     = mouse_db9 ? hid_joy[2] : hid_joy[1];
      end
    endcase
  end

  // port 0 is a mouse by default, a joystick button takes it over
  // for two player games and a mouse button hands it back
  always_ff @(posedge clk32) begin
    if (!rst_n) begin
      mouse_active <= 1'b1;
    end else if (port0_mouse.fire || port0_mouse.fire2) begin
      mouse_active <= 1'b1;
    end else if (port0_joy.fire || port0_joy.fire2) begin
      mouse_active <= 1'b0;
    end
  end

  assign joy0 = mouse_active ? port0_mouse : port0_joy;

  // gauntlet ii adapter, lines are active low on the printer port
  assign par_in.strobe = ~port3.fire;
  assign par_in.busy   = ~port2.fire;
  assign par_in.data   = ~{port2.up, port2.down, port2.left, port2.right,
                           port3.up, port3.down, port3.left, port3.right};

  // report port 0 unless a db9 mouse sits there, then the spare port
  assign hid_db9 = mouse_db9 ? db9_1 : db9_0_atari;

endmodule

`default_nettype wire

//--- st_io_pkg.sv
// device side types: st ports, db9 pins, hid joysticks, audio samples, printer port
`default_nettype none

`include "st_glue_consts.svh"

package st_io_pkg;

  // one st joystick/mouse port, active high, up sits at bit 0
  typedef struct packed {
    logic fire2; // bit 5, second button / right mouse button
    logic fire;  // bit 4
    logic right; // bit 3
    logic left;  // bit 2
    logic down;  // bit 1
    logic up;    // bit 0
  } st_port_t;

  // raw db9 pins straight from the board, active low
  typedef logic [`ST_PORT_W-1:0] db9_pins_t;

  // hid joysticks, buttons beyond the second are not routed
  typedef st_port_t [`ST_HID_JOY_N-1:0] hid_joys_t;

  // printer port inputs as seen by the st core
  typedef struct packed {
    logic       strobe; // fire of port 3, inverted
    logic       busy;   // fire of port 2, inverted
    logic [7:0] data;   // directions of ports 2 and 3, inverted
  } par_in_t;

  typedef logic signed [`ST_AUDIO_IN_W-1:0] sample_in_t; // core mixer sample
  typedef logic signed [`ST_AUDIO_W-1:0]    sample_t;    // scaled output sample

  typedef logic [`ST_RAM_AW-1:0] ram_addr_t; // sdram word address

endpackage

`default_nettype wire

//--- st_cfg_pkg.sv
// system setting types as set by the user through the osd menu
`default_nettype none

package st_cfg_pkg;

  // device feeding st port 0 as mouse
  typedef enum logic [1:0] {
    msrc_hid       = 2'd0, // usb mouse via mcu
    msrc_atari_db9 = 2'd1, // atari st mouse on the io db9
    msrc_amiga_db9 = 2'd2  // amiga mouse, quadrature lines swapped
  } mouse_src_e;

  // number of classic db9 joysticks plugged in
  // they are passive so this cannot be detected
  typedef enum logic [1:0] {
    joy_none = 2'd0,
    joy_one  = 2'd1,
    joy_two  = 2'd2  // second one sits on the spare pins
  } joy_cfg_e;

  // output volume, applied as arithmetic shift
  typedef enum logic [1:0] {
    vol_mute    = 2'd0,
    vol_quarter = 2'd1,
    vol_half    = 2'd2,
    vol_full    = 2'd3
  } volume_e;

  // settings word, 8 bits
  typedef struct packed {
    mouse_src_e mouse_src; // [7:6]
    joy_cfg_e   joy_cfg;   // [5:4]
    volume_e    volume;    // [3:2]
    logic       reset_req; // osd reset, held while high
    logic       coldboot;  // rising edge invalidates ram contents
  } sys_cfg_t;

endpackage

`default_nettype wire

//--- st_glue_consts.svh
// st glue constants: port, audio and address widths, boot wait and ram scramble position
`ifndef ST_GLUE_CONSTS_SVH
`define ST_GLUE_CONSTS_SVH

// one st joystick port: up, down, left, right, fire, second button
`define ST_PORT_W 6

// usb/hid joysticks handed over by the mcu
`define ST_HID_JOY_N 4

// audio sample widths
`define ST_AUDIO_IN_W 15 // mixer output of the st core
`define ST_AUDIO_W 16    // volume scaled output towards dac / hdmi

// sdram word address width as seen by the core
`define ST_RAM_AW 22

// cold-boot scramble: address bits 3 and 4 get xored with the counter
`define ST_SCRAMBLE_LSB 3
`define ST_SCRAMBLE_W 2

// how long the core waits for a disk image before booting anyway
// 2 s at 32 MHz
`define ST_SD_WAIT_DEFAULT 64000000

`endif
